//--- rtl/isaPkg.sv
`default_nettype none

package isaPkg;

    localparam int wordWidth = 16;

    typedef logic [wordWidth-1:0] wordT;
    typedef logic [1:0] regIdxT;

    typedef enum logic [3:0] {
        opBne   = 4'd0,
        opBeq   = 4'd1,
        opAdi   = 4'd4,
        opLwd   = 4'd7,
        opSwd   = 4'd8,
        opJmp   = 4'd9,
        opRtype = 4'd15
    } opcodeT;

    typedef enum logic [5:0] {
        fnAdd = 6'd0,
        fnSub = 6'd1,
        fnAnd = 6'd2,
        fnOrr = 6'd3,
        fnWwd = 6'd28,
        fnHlt = 6'd29
    } funcT;

    // instruction fields
    localparam int opcodeMsb = 15;
    localparam int opcodeLsb = 12;
    localparam int rsMsb     = 11;
    localparam int rsLsb     = 10;
    localparam int rtMsb     = 9;
    localparam int rtLsb     = 8;
    localparam int rdMsb     = 7;
    localparam int rdLsb     = 6;
    localparam int funcMsb   = 5;
    localparam int funcLsb   = 0;
    localparam int immMsb    = 7;   // sign bit of the 8-bit immediate
    localparam int immLsb    = 0;
    localparam int targetMsb = 11;
    localparam int targetLsb = 0;

    // bubble word, decoded as no write and no retire
    localparam wordT nopWord = {opAdi, 12'h000};

endpackage

`default_nettype wire

//--- rtl/pipePkg.sv
`default_nettype none

package pipePkg;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluPassA    // rs straight through, for WWD
    } aluOpT;

    // operand source in execute
    typedef enum logic [1:0] {
        fromReg,
        fromMem,
        fromWb
    } fwdSelT;

endpackage

`default_nettype wire

//--- rtl/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  logic           clk,
    input  logic           arstN,
    input  isaPkg::regIdxT rsIdx,
    input  isaPkg::regIdxT rtIdx,
    input  isaPkg::regIdxT wrIdx,
    input  isaPkg::wordT   wrData,
    input  logic           wrEn,
    output isaPkg::wordT   rsData,
    output isaPkg::wordT   rtData
);
    isaPkg::wordT regs [4];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 4; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[wrIdx] <= wrData;
        end
    end

    // WB write seen by decode in the same cycle
    assign rsData = (wrEn && wrIdx == rsIdx) ? wrData : regs[rsIdx];
    assign rtData = (wrEn && wrIdx == rtIdx) ? wrData : regs[rtIdx];

endmodule

`default_nettype wire

//--- rtl/decodeUnit.sv
`timescale 1ns/1ps
`default_nettype none

module decodeUnit (
    input  isaPkg::wordT   instr,
    input  isaPkg::wordT   pc,
    input  isaPkg::wordT   rsData,
    input  isaPkg::wordT   rtData,
    input  isaPkg::regIdxT exDest,
    input  logic           exRegWrite,
    input  logic           exMemRead,
    input  isaPkg::regIdxT memDest,
    input  logic           memRegWrite,
    output isaPkg::regIdxT rsIdx,
    output isaPkg::regIdxT rtIdx,
    output isaPkg::regIdxT dest,
    output isaPkg::wordT   imm,
    output pipePkg::aluOpT aluOp,
    output logic           aluSrcImm,
    output logic           memRead,
    output logic           memWrite,
    output logic           regWrite,
    output logic           isWwd,
    output logic           isHalt,
    output logic           retire,
    output logic           stall,
    output logic           pcRedirect,
    output isaPkg::wordT   redirectTarget
);
    isaPkg::opcodeT opcode;
    isaPkg::funcT   func;
    logic           isBubble;
    logic           usesRs;
    logic           usesRt;
    logic           isBranch;
    logic           isJump;
    logic           loadUse;
    logic           branchHazard;
    logic           taken;

    assign opcode   = isaPkg::opcodeT'(instr[isaPkg::opcodeMsb:isaPkg::opcodeLsb]);
    assign func     = isaPkg::funcT'(instr[isaPkg::funcMsb:isaPkg::funcLsb]);
    assign rsIdx    = instr[isaPkg::rsMsb:isaPkg::rsLsb];
    assign rtIdx    = instr[isaPkg::rtMsb:isaPkg::rtLsb];
    assign imm      = {{8{instr[isaPkg::immMsb]}}, instr[isaPkg::immMsb:isaPkg::immLsb]};
    assign isBubble = (instr == isaPkg::nopWord);
    assign retire   = !isBubble;

    always_comb begin
        aluOp     = pipePkg::aluAdd;
        aluSrcImm = 1'b0;
        memRead   = 1'b0;
        memWrite  = 1'b0;
        regWrite  = 1'b0;
        isWwd     = 1'b0;
        isHalt    = 1'b0;
        usesRs    = 1'b0;
        usesRt    = 1'b0;
        isBranch  = 1'b0;
        isJump    = 1'b0;
        dest      = rtIdx;
        case (opcode)
            isaPkg::opRtype: begin
                dest     = instr[isaPkg::rdMsb:isaPkg::rdLsb];
                usesRs   = 1'b1;
                usesRt   = 1'b1;
                regWrite = 1'b1;
                case (func)
                    isaPkg::fnAdd: aluOp = pipePkg::aluAdd;
                    isaPkg::fnSub: aluOp = pipePkg::aluSub;
                    isaPkg::fnAnd: aluOp = pipePkg::aluAnd;
                    isaPkg::fnOrr: aluOp = pipePkg::aluOr;
                    isaPkg::fnWwd: begin
                        aluOp    = pipePkg::aluPassA;
                        usesRt   = 1'b0;
                        regWrite = 1'b0;
                        isWwd    = 1'b1;
                    end
                    isaPkg::fnHlt: begin
                        usesRs   = 1'b0;
                        usesRt   = 1'b0;
                        regWrite = 1'b0;
                        isHalt   = 1'b1;
                    end
                    default: begin      // unsupported func, flows as a no-op
                        usesRs   = 1'b0;
                        usesRt   = 1'b0;
                        regWrite = 1'b0;
                    end
                endcase
            end
            isaPkg::opAdi: begin
                usesRs    = 1'b1;
                aluSrcImm = 1'b1;
                regWrite  = !isBubble;
            end
            isaPkg::opLwd: begin
                usesRs    = 1'b1;
                aluSrcImm = 1'b1;
                memRead   = 1'b1;
                regWrite  = 1'b1;
            end
            isaPkg::opSwd: begin
                usesRs    = 1'b1;
                usesRt    = 1'b1;   // store data
                aluSrcImm = 1'b1;
                memWrite  = 1'b1;
            end
            isaPkg::opBne, isaPkg::opBeq: begin
                usesRs   = 1'b1;
                usesRt   = 1'b1;
                isBranch = 1'b1;
            end
            isaPkg::opJmp: isJump = 1'b1;
            default: ;
        endcase
    end

    assign loadUse = exMemRead && ((usesRs && exDest == rsIdx) || (usesRt && exDest == rtIdx));
    // compare happens here, so any pending writer in EX or MEM must reach WB first
    assign branchHazard = isBranch
        && ((exRegWrite && (exDest == rsIdx || exDest == rtIdx))
        || (memRegWrite && (memDest == rsIdx || memDest == rtIdx)));
    assign stall = loadUse || branchHazard;

    assign taken      = (opcode == isaPkg::opBeq) ? (rsData == rtData) : (rsData != rtData);
    assign pcRedirect = !stall && (isJump || (isBranch && taken));
    assign redirectTarget = isJump
        ? {pc[isaPkg::wordWidth-1:isaPkg::targetMsb+1], instr[isaPkg::targetMsb:isaPkg::targetLsb]}
        : pc + 16'd1 + imm;

endmodule

`default_nettype wire

//--- rtl/execUnit.sv
`timescale 1ns/1ps
`default_nettype none

module execUnit (
    input  isaPkg::wordT   rsVal,
    input  isaPkg::wordT   rtVal,
    input  isaPkg::wordT   imm,
    input  isaPkg::regIdxT rsIdx,
    input  isaPkg::regIdxT rtIdx,
    input  pipePkg::aluOpT aluOp,
    input  logic           aluSrcImm,
    input  isaPkg::regIdxT memDest,
    input  logic           memRegWrite,
    input  isaPkg::wordT   memResult,
    input  isaPkg::regIdxT wbDest,
    input  logic           wbRegWrite,
    input  isaPkg::wordT   wbData,
    output isaPkg::wordT   aluResult,
    output isaPkg::wordT   storeData
);
    pipePkg::fwdSelT rsSel;
    pipePkg::fwdSelT rtSel;
    isaPkg::wordT    opA;
    isaPkg::wordT    rtFwd;
    isaPkg::wordT    opB;

    // youngest writer first
    function automatic pipePkg::fwdSelT selectSource(isaPkg::regIdxT idx);
        if (memRegWrite && memDest == idx) return pipePkg::fromMem;
        else if (wbRegWrite && wbDest == idx) return pipePkg::fromWb;
        else return pipePkg::fromReg;
    endfunction

    function automatic isaPkg::wordT pickOperand(pipePkg::fwdSelT sel, isaPkg::wordT regVal);
        case (sel)
            pipePkg::fromMem: return memResult;
            pipePkg::fromWb:  return wbData;
            default:          return regVal;
        endcase
    endfunction

    always_comb begin
        rsSel = selectSource(rsIdx);
        rtSel = selectSource(rtIdx);
        opA   = pickOperand(rsSel, rsVal);
        rtFwd = pickOperand(rtSel, rtVal);
        opB   = aluSrcImm ? imm : rtFwd;   // imm select after forwarding
        case (aluOp)
            pipePkg::aluAdd:   aluResult = opA + opB;
            pipePkg::aluSub:   aluResult = opA - opB;
            pipePkg::aluAnd:   aluResult = opA & opB;
            pipePkg::aluOr:    aluResult = opA | opB;
            pipePkg::aluPassA: aluResult = opA;
            default:           aluResult = '0;
        endcase
    end

    assign storeData = rtFwd;

endmodule

`default_nettype wire

//--- rtl/cpuCore.sv
`timescale 1ns/1ps
`default_nettype none

module cpuCore (
    input  logic         clk,
    input  logic         arstN,
    output isaPkg::wordT instAddr,
    input  isaPkg::wordT instData,
    output logic         dataRead,
    output logic         dataWrite,
    output isaPkg::wordT dataAddr,
    output isaPkg::wordT dataWdata,
    input  isaPkg::wordT dataRdata,
    output logic         wwdValid,
    output isaPkg::wordT wwdData,
    output isaPkg::wordT numInst,
    output logic         halted
);
    isaPkg::wordT   pc;
    logic           haltSeen;       // HLT left decode, fetch stays frozen
    logic           freezeFetch;
    isaPkg::wordT   ifIdInstr;
    isaPkg::wordT   ifIdPc;

    isaPkg::regIdxT decRsIdx;
    isaPkg::regIdxT decRtIdx;
    isaPkg::regIdxT decDest;
    isaPkg::wordT   decRsData;
    isaPkg::wordT   decRtData;
    isaPkg::wordT   decImm;
    isaPkg::wordT   decTarget;
    pipePkg::aluOpT decAluOp;
    logic           decAluSrcImm;
    logic           decMemRead;
    logic           decMemWrite;
    logic           decRegWrite;
    logic           decIsWwd;
    logic           decIsHalt;
    logic           decRetire;
    logic           decStall;
    logic           decRedirect;

    isaPkg::wordT   idExRsVal;
    isaPkg::wordT   idExRtVal;
    isaPkg::wordT   idExImm;
    isaPkg::regIdxT idExRsIdx;
    isaPkg::regIdxT idExRtIdx;
    isaPkg::regIdxT idExDest;
    pipePkg::aluOpT idExAluOp;
    logic           idExAluSrcImm;
    logic           idExMemRead;
    logic           idExMemWrite;
    logic           idExRegWrite;
    logic           idExIsWwd;
    logic           idExIsHalt;
    logic           idExRetire;

    isaPkg::wordT   exAluResult;
    isaPkg::wordT   exStoreData;
    isaPkg::wordT   exMemResult;
    isaPkg::wordT   exMemStoreData;
    isaPkg::regIdxT exMemDest;
    logic           exMemMemRead;
    logic           exMemMemWrite;
    logic           exMemRegWrite;
    logic           exMemIsWwd;
    logic           exMemIsHalt;
    logic           exMemRetire;

    isaPkg::wordT   memWbResult;
    isaPkg::wordT   memWbLoadData;
    isaPkg::regIdxT memWbDest;
    logic           memWbMemToReg;
    logic           memWbRegWrite;
    logic           memWbIsWwd;
    logic           memWbIsHalt;
    logic           memWbRetire;
    isaPkg::wordT   wbData;

    assign instAddr    = pc;
    assign freezeFetch = haltSeen || (decIsHalt && !decStall);

    // fetch and IF/ID, stall wins over redirect
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc        <= '0;
            haltSeen  <= 1'b0;
            ifIdInstr <= isaPkg::nopWord;
            ifIdPc    <= '0;
        end else if (!decStall) begin
            if (decIsHalt) begin
                haltSeen <= 1'b1;
            end
            if (freezeFetch) begin
                ifIdInstr <= isaPkg::nopWord;
            end else if (decRedirect) begin
                pc        <= decTarget;
                ifIdInstr <= isaPkg::nopWord;   // flushed slot
            end else begin
                pc        <= pc + 16'd1;
                ifIdInstr <= instData;
                ifIdPc    <= pc;
            end
        end
    end

    regFile uRegFile (
        .clk    (clk),
        .arstN  (arstN),
        .rsIdx  (decRsIdx),
        .rtIdx  (decRtIdx),
        .wrIdx  (memWbDest),
        .wrData (wbData),
        .wrEn   (memWbRegWrite),
        .rsData (decRsData),
        .rtData (decRtData)
    );

    decodeUnit uDecode (
        .instr          (ifIdInstr),
        .pc             (ifIdPc),
        .rsData         (decRsData),
        .rtData         (decRtData),
        .exDest         (idExDest),
        .exRegWrite     (idExRegWrite),
        .exMemRead      (idExMemRead),
        .memDest        (exMemDest),
        .memRegWrite    (exMemRegWrite),
        .rsIdx          (decRsIdx),
        .rtIdx          (decRtIdx),
        .dest           (decDest),
        .imm            (decImm),
        .aluOp          (decAluOp),
        .aluSrcImm      (decAluSrcImm),
        .memRead        (decMemRead),
        .memWrite       (decMemWrite),
        .regWrite       (decRegWrite),
        .isWwd          (decIsWwd),
        .isHalt         (decIsHalt),
        .retire         (decRetire),
        .stall          (decStall),
        .pcRedirect     (decRedirect),
        .redirectTarget (decTarget)
    );

    // ID/EX, a stall leaves a bubble behind
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            idExRsVal     <= '0;
            idExRtVal     <= '0;
            idExImm       <= '0;
            idExRsIdx     <= '0;
            idExRtIdx     <= '0;
            idExDest      <= '0;
            idExAluOp     <= pipePkg::aluAdd;
            idExAluSrcImm <= 1'b0;
            idExMemRead   <= 1'b0;
            idExMemWrite  <= 1'b0;
            idExRegWrite  <= 1'b0;
            idExIsWwd     <= 1'b0;
            idExIsHalt    <= 1'b0;
            idExRetire    <= 1'b0;
        end else begin
            idExRsVal     <= decRsData;
            idExRtVal     <= decRtData;
            idExImm       <= decImm;
            idExRsIdx     <= decRsIdx;
            idExRtIdx     <= decRtIdx;
            idExDest      <= decDest;
            idExAluOp     <= decAluOp;
            idExAluSrcImm <= decAluSrcImm;
            idExMemRead   <= decMemRead && !decStall;
            idExMemWrite  <= decMemWrite && !decStall;
            idExRegWrite  <= decRegWrite && !decStall;
            idExIsWwd     <= decIsWwd && !decStall;
            idExIsHalt    <= decIsHalt && !decStall;
            idExRetire    <= decRetire && !decStall;
        end
    end

    execUnit uExec (
        .rsVal       (idExRsVal),
        .rtVal       (idExRtVal),
        .imm         (idExImm),
        .rsIdx       (idExRsIdx),
        .rtIdx       (idExRtIdx),
        .aluOp       (idExAluOp),
        .aluSrcImm   (idExAluSrcImm),
        .memDest     (exMemDest),
        .memRegWrite (exMemRegWrite),
        .memResult   (exMemResult),
        .wbDest      (memWbDest),
        .wbRegWrite  (memWbRegWrite),
        .wbData      (wbData),
        .aluResult   (exAluResult),
        .storeData   (exStoreData)
    );

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            exMemResult    <= '0;
            exMemStoreData <= '0;
            exMemDest      <= '0;
            exMemMemRead   <= 1'b0;
            exMemMemWrite  <= 1'b0;
            exMemRegWrite  <= 1'b0;
            exMemIsWwd     <= 1'b0;
            exMemIsHalt    <= 1'b0;
            exMemRetire    <= 1'b0;
        end else begin
            exMemResult    <= exAluResult;
            exMemStoreData <= exStoreData;
            exMemDest      <= idExDest;
            exMemMemRead   <= idExMemRead;
            exMemMemWrite  <= idExMemWrite;
            exMemRegWrite  <= idExRegWrite;
            exMemIsWwd     <= idExIsWwd;
            exMemIsHalt    <= idExIsHalt;
            exMemRetire    <= idExRetire;
        end
    end

    // data port, address comes from the ALU
    assign dataRead  = exMemMemRead;
    assign dataWrite = exMemMemWrite;
    assign dataAddr  = exMemResult;
    assign dataWdata = exMemStoreData;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            memWbResult   <= '0;
            memWbLoadData <= '0;
            memWbDest     <= '0;
            memWbMemToReg <= 1'b0;
            memWbRegWrite <= 1'b0;
            memWbIsWwd    <= 1'b0;
            memWbIsHalt   <= 1'b0;
            memWbRetire   <= 1'b0;
        end else begin
            memWbResult   <= exMemResult;
            memWbLoadData <= dataRdata;
            memWbDest     <= exMemDest;
            memWbMemToReg <= exMemMemRead;
            memWbRegWrite <= exMemRegWrite;
            memWbIsWwd    <= exMemIsWwd;
            memWbIsHalt   <= exMemIsHalt;
            memWbRetire   <= exMemRetire;
        end
    end

    assign wbData   = memWbMemToReg ? memWbLoadData : memWbResult;
    assign wwdValid = memWbIsWwd;
    assign wwdData  = memWbResult;   // rs value via PASSA

    // numInst and halted move on the same edge
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            numInst <= '0;
            halted  <= 1'b0;
        end else begin
            if (memWbRetire) begin
                numInst <= numInst + 16'd1;
            end
            if (memWbIsHalt) begin
                halted <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- verif/cpuCore_properties.sv
`timescale 1ns/1ps
`default_nettype none

module cpuCore_properties (
    input logic         clk,
    input logic         arstN,
    input logic         dataRead,
    input logic         dataWrite,
    input logic         halted,
    input isaPkg::wordT numInst
);

    // one memory access per cycle on the data port
    noReadWriteOverlap: assert property (@(posedge clk) disable iff (!arstN)
        !(dataRead && dataWrite))
        else $error("dataRead and dataWrite high in the same cycle");

    haltSticks: assert property (@(posedge clk) disable iff (!arstN)
        $past(halted) |-> halted)
        else $error("halted fell while out of reset");

    countMonotonic: assert property (@(posedge clk) disable iff (!arstN)
        numInst >= $past(numInst))
        else $error("numInst decreased");

endmodule

bind cpuCore cpuCore_properties props (
    .clk       (clk),
    .arstN     (arstN),
    .dataRead  (dataRead),
    .dataWrite (dataWrite),
    .halted    (halted),
    .numInst   (numInst)
);

`default_nettype wire

//--- verif/cpuTb.sv
`timescale 1ns/1ps
`default_nettype none

module cpuTb;

    localparam int haltTimeout = 400;   // cycles
    localparam int watchCycles = 20;

    logic         clk;
    logic         arstN;
    isaPkg::wordT instAddr;
    isaPkg::wordT instData;
    logic         dataRead;
    logic         dataWrite;
    isaPkg::wordT dataAddr;
    isaPkg::wordT dataWdata;
    isaPkg::wordT dataRdata;
    logic         wwdValid;
    isaPkg::wordT wwdData;
    isaPkg::wordT numInst;
    logic         halted;

    isaPkg::wordT imem [256];
    isaPkg::wordT dmem [256];
    isaPkg::wordT initMem [256];
    isaPkg::wordT refMem [256];
    isaPkg::wordT expWwd [$];
    isaPkg::wordT refCount;
    int           errCount = 0;
    int           wwdErrCount = 0;
    int           wwdSeen = 0;

    cpuCore dut (
        .clk       (clk),
        .arstN     (arstN),
        .instAddr  (instAddr),
        .instData  (instData),
        .dataRead  (dataRead),
        .dataWrite (dataWrite),
        .dataAddr  (dataAddr),
        .dataWdata (dataWdata),
        .dataRdata (dataRdata),
        .wwdValid  (wwdValid),
        .wwdData   (wwdData),
        .numInst   (numInst),
        .halted    (halted)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // both memories decode only the low byte of the address
    assign instData  = imem[instAddr[7:0]];
    assign dataRdata = dataRead ? dmem[dataAddr[7:0]] : '0;   // data only on a read

    always @(posedge clk) begin
        if (!arstN) begin
            for (int i = 0; i < 256; i++) begin
                dmem[i] <= initMem[i];   // preload while in reset
            end
        end else if (dataWrite) begin
            dmem[dataAddr[7:0]] <= dataWdata;
        end
    end

    function automatic isaPkg::wordT encodeR(isaPkg::regIdxT rs, isaPkg::regIdxT rt,
                                             isaPkg::regIdxT rd, isaPkg::funcT fn);
        return {isaPkg::opRtype, rs, rt, rd, fn};
    endfunction

    function automatic isaPkg::wordT encodeI(isaPkg::opcodeT op, isaPkg::regIdxT rs,
                                             isaPkg::regIdxT rt, logic [7:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic isaPkg::wordT encodeJump(logic [11:0] target);
        return {isaPkg::opJmp, target};
    endfunction

    task automatic buildProgram();
        logic [7:0] immA;
        logic [7:0] immB;
        logic [7:0] immC;
        logic [7:0] immD;
        logic [7:0] ldAddr;
        logic [7:0] stAddr;
        logic [7:0] stAddr2;
        logic [7:0] skipAddr;
        immA     = 8'($urandom());
        immB     = 8'($urandom());
        immC     = 8'($urandom());
        immD     = 8'($urandom_range(127, 1));   // nonzero, steers the r2 branches
        ldAddr   = 8'($urandom_range(63, 0));
        stAddr   = 8'($urandom_range(95, 64));
        stAddr2  = 8'($urandom_range(111, 96));
        skipAddr = 8'($urandom_range(127, 112));
        for (int i = 0; i < 256; i++) begin
            imem[i]    = encodeR(2'd0, 2'd0, 2'd0, isaPkg::fnHlt);   // stray fetches halt
            initMem[i] = 16'($urandom());
        end
        imem[0]  = encodeI(isaPkg::opAdi, 2'd0, 2'd1, immA);
        imem[1]  = encodeI(isaPkg::opAdi, 2'd1, 2'd2, immB);
        imem[2]  = encodeR(2'd1, 2'd2, 2'd3, isaPkg::fnAdd);
        imem[3]  = encodeR(2'd3, 2'd2, 2'd1, isaPkg::fnSub);
        imem[4]  = encodeR(2'd1, 2'd3, 2'd2, isaPkg::fnAnd);
        imem[5]  = encodeR(2'd2, 2'd1, 2'd3, isaPkg::fnOrr);
        imem[6]  = encodeR(2'd1, 2'd0, 2'd0, isaPkg::fnWwd);
        imem[7]  = encodeR(2'd2, 2'd0, 2'd0, isaPkg::fnWwd);
        imem[8]  = encodeR(2'd3, 2'd0, 2'd0, isaPkg::fnWwd);
        imem[9]  = encodeI(isaPkg::opLwd, 2'd0, 2'd1, ldAddr);
        imem[10] = encodeR(2'd1, 2'd3, 2'd2, isaPkg::fnAdd);   // load-use
        imem[11] = encodeR(2'd2, 2'd0, 2'd0, isaPkg::fnWwd);
        imem[12] = encodeI(isaPkg::opSwd, 2'd0, 2'd2, stAddr);
        imem[13] = encodeI(isaPkg::opLwd, 2'd0, 2'd3, stAddr);
        imem[14] = encodeR(2'd3, 2'd0, 2'd0, isaPkg::fnWwd);
        imem[15] = encodeI(isaPkg::opBeq, 2'd3, 2'd2, 8'd1);   // taken
        imem[16] = encodeR(2'd1, 2'd0, 2'd0, isaPkg::fnWwd);
        imem[17] = encodeI(isaPkg::opBne, 2'd3, 2'd2, 8'd2);   // not taken
        imem[18] = encodeI(isaPkg::opAdi, 2'd1, 2'd1, immC);
        imem[19] = encodeI(isaPkg::opBeq, 2'd1, 2'd1, 8'd1);   // right after producer
        imem[20] = encodeI(isaPkg::opSwd, 2'd0, 2'd1, skipAddr);   // flushed, own address
        imem[21] = encodeI(isaPkg::opAdi, 2'd0, 2'd2, immD);
        imem[22] = encodeI(isaPkg::opBne, 2'd2, 2'd0, 8'd1);
        imem[23] = encodeR(2'd2, 2'd0, 2'd0, isaPkg::fnWwd);
        imem[24] = encodeI(isaPkg::opBeq, 2'd2, 2'd0, 8'd1);
        imem[25] = encodeR(2'd2, 2'd0, 2'd0, isaPkg::fnWwd);
        imem[26] = encodeJump(12'd28);
        imem[27] = encodeR(2'd3, 2'd0, 2'd0, isaPkg::fnWwd);
        imem[28] = encodeI(isaPkg::opSwd, 2'd0, 2'd1, stAddr2);
        imem[29] = encodeR(2'd1, 2'd0, 2'd0, isaPkg::fnWwd);
        imem[30] = encodeR(2'd0, 2'd0, 2'd0, isaPkg::fnHlt);
        imem[31] = encodeR(2'd3, 2'd0, 2'd0, isaPkg::fnWwd);   // fetched behind HLT only
    endtask

    // ISA-level model, fills expWwd and refMem and returns the executed count
    function automatic isaPkg::wordT interpret();
        isaPkg::wordT regs [4];
        isaPkg::wordT pc;
        isaPkg::wordT curPc;
        isaPkg::wordT ins;
        isaPkg::wordT imm;
        isaPkg::wordT addr;
        isaPkg::wordT count;
        logic [1:0]   rs;
        logic [1:0]   rt;
        logic [1:0]   rd;
        bit           done;
        for (int i = 0; i < 4; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < 256; i++) begin
            refMem[i] = initMem[i];
        end
        pc    = '0;
        count = '0;
        done  = 1'b0;
        for (int step = 0; step < 1000 && !done; step++) begin
            curPc = pc;
            ins   = imem[pc[7:0]];
            rs    = ins[11:10];
            rt    = ins[9:8];
            rd    = ins[7:6];
            imm   = {{8{ins[7]}}, ins[7:0]};
            addr  = regs[rs] + imm;
            pc    = pc + 16'd1;
            count = count + 16'd1;
            case (isaPkg::opcodeT'(ins[15:12]))
                isaPkg::opRtype: begin
                    case (isaPkg::funcT'(ins[5:0]))
                        isaPkg::fnAdd: regs[rd] = regs[rs] + regs[rt];
                        isaPkg::fnSub: regs[rd] = regs[rs] - regs[rt];
                        isaPkg::fnAnd: regs[rd] = regs[rs] & regs[rt];
                        isaPkg::fnOrr: regs[rd] = regs[rs] | regs[rt];
                        isaPkg::fnWwd: expWwd.push_back(regs[rs]);
                        isaPkg::fnHlt: done = 1'b1;
                        default: ;
                    endcase
                end
                isaPkg::opAdi: regs[rt] = addr;
                isaPkg::opLwd: regs[rt] = refMem[addr[7:0]];
                isaPkg::opSwd: refMem[addr[7:0]] = regs[rt];
                isaPkg::opBne: pc = (regs[rs] != regs[rt]) ? pc + imm : pc;
                isaPkg::opBeq: pc = (regs[rs] == regs[rt]) ? pc + imm : pc;
                isaPkg::opJmp: pc = {curPc[15:12], ins[11:0]};
                default: ;
            endcase
        end
        return count;
    endfunction

    task automatic checkWord(input string name, input isaPkg::wordT expected,
                             input isaPkg::wordT actual, inout int errs);
        if (actual !== expected) begin
            $display("[ERROR] %s expected %h actual %h", name, expected, actual);
            errs++;
        end
    endtask

    task automatic checkCount(input string name, input isaPkg::wordT expected,
                              input isaPkg::wordT actual, inout int errs);
        if (actual !== expected) begin
            $display("[ERROR] %s expected %0d actual %0d", name, expected, actual);
            errs++;
        end
    endtask

    // every WWD pulse against the next expected value
    always @(negedge clk) begin
        if (arstN && wwdValid) begin
            if (wwdSeen < expWwd.size()) begin
                checkWord($sformatf("wwd %0d", wwdSeen), expWwd[wwdSeen], wwdData, wwdErrCount);
            end else begin
                $display("unexpected WWD output %h after the expected sequence", wwdData);
                wwdErrCount++;
            end
            wwdSeen++;
        end
    end

    initial begin
        int cycles;
        arstN <= 1'b0;
        void'($urandom(32'h8b34));
        buildProgram();
        refCount = interpret();
        repeat (5) @(posedge clk);
        arstN <= 1'b1;

        cycles = 0;
        while (!halted && cycles < haltTimeout) begin
            @(negedge clk);
            cycles++;
        end
        if (!halted) begin
            $display("timeout: halted did not rise within %0d cycles", haltTimeout);
            errCount++;
        end else begin
            checkCount("numInst", refCount, numInst, errCount);
            repeat (watchCycles) begin
                @(negedge clk);
                if (!halted) begin
                    $display("halted went low again after the core stopped");
                    errCount++;
                end
            end
            checkCount("wwd outputs", 16'(expWwd.size()), 16'(wwdSeen), errCount);
            for (int i = 0; i < 256; i++) begin
                checkWord($sformatf("dmem[%0d]", i), refMem[i], dmem[i], errCount);
            end
        end

        $display("errors %0d, wwd errors %0d, wwd outputs %0d of %0d",
                 errCount, wwdErrCount, wwdSeen, expWwd.size());
        if (errCount == 0 && wwdErrCount == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
rtl/isaPkg.sv
rtl/pipePkg.sv
rtl/regFile.sv
rtl/decodeUnit.sv
rtl/execUnit.sv
rtl/cpuCore.sv
verif/cpuCore_properties.sv
verif/cpuTb.sv

//--- run.sh
#!/bin/sh
# Verilator build and run of the cpuCore testbench

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module cpuTb -Mdir obj_dir -f flist.f; then
    echo "Verilator build failed"
    exit 1
fi

simOut=$(./obj_dir/VcpuTb)
simStatus=$?
printf '%s\n' "$simOut"

if [ "$simStatus" -ne 0 ]; then
    echo "simulator exited with status $simStatus"
    exit 1
fi

if printf '%s\n' "$simOut" | grep -qx 'Simulation passed'; then
    exit 0
fi
exit 1
